//--- mac_frame_gen.f
+incdir+.
mac_frame_gen_pkg.sv
crc32_engine.sv
payload_source.sv
frame_sequencer.sv
mac_frame_gen.sv
tb_mac_frame_gen.sv

//--- tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// bit at a time, byte lsb first, reflected 802.3 polynomial
function automatic crc_t crc_fold(input crc_t crc, input byte_t b);
    logic fb;
    for (int i = 0; i < 8; i++) begin
        fb  = crc[0] ^ b[i];
        crc = crc >> 1;
        if (fb) begin
            crc = crc ^ 32'hEDB88320;
        end
    end
    return crc;
endfunction

// fills exp_q with the whole frame as it should appear on o_data
task automatic build_expected(input mac_addr_t dest, input mac_addr_t src, input len_type_t lt,
                              input byte_t [PAYLOAD_LEN-1:0] pl, input payload_mode_t mode);
    logic [111:0] hdr;
    crc_t         crc;
    int           flen;
    byte_t        b;
    bit           fill;
    hdr  = {dest, src, lt}; // msb first on the wire
    crc  = 32'hFFFFFFFF;
    fill = (mode == MODE_FIXED) || (mode == MODE_FIXED_NO_PAD);
    flen = PAYLOAD_LEN;
    if ((mode == MODE_NORMAL || mode == MODE_FIXED) && PAYLOAD_LEN < 46) begin
        flen = 46; // zero pad to minimum
    end
    exp_q.delete();
    for (int i = 0; i < 8; i++) begin
        exp_q.push_back((i == 7) ? 8'hD5 : 8'h55); // sfd closes the preamble
    end
    for (int i = 0; i < 14 + flen; i++) begin
        if (i < 14) begin
            b = hdr[111 - 8 * i -: 8];
        end else if (fill) begin
            b = FILL_BYTE;       // padding bytes too
        end else if (i - 14 < PAYLOAD_LEN) begin
            b = pl[i - 14];
        end else begin
            b = 8'h00;
        end
        crc = crc_fold(crc, b);
        exp_q.push_back(b);
    end
    crc = ~crc;
    for (int i = 0; i < 4; i++) begin
        exp_q.push_back(crc[8 * i +: 8]); // fcs lsb first
    end
endtask

`endif

//--- tb_mac_frame_gen.sv
module tb_mac_frame_gen;
    timeunit 1ns;
    timeprecision 100ps;

    import mac_frame_gen_pkg::*;

    localparam integer PAYLOAD_LEN = 20;   // below 46 so padding matters
    localparam byte_t  FILL_BYTE   = 8'hA7;
    localparam integer N_FRAMES    = 40;
    localparam integer MAX_FIELD   = (PAYLOAD_LEN > 46) ? PAYLOAD_LEN : 46;
    localparam integer CYCLE_LIMIT = N_FRAMES * (8 + 14 + MAX_FIELD + 4 + 8) + 100;

    logic                    clk = 1'b0;
    logic                    i_rst_n;
    logic                    i_start;
    mac_addr_t               i_dest_addr;
    mac_addr_t               i_src_addr;
    len_type_t               i_len_type;
    byte_t [PAYLOAD_LEN-1:0] i_payload;
    payload_mode_t           i_mode;
    byte_t                   o_data;
    logic                    o_valid;
    logic                    o_done;

    byte_t exp_q[$];          // expected frame bytes
    int    rx_idx     = 0;    // next expected byte
    int    run_len    = 0;    // length of current valid run
    int    cycles     = 0;
    int    err_cnt    = 0;
    int    pass_cnt   = 0;
    int    fail_cnt   = 0;
    int    seed;
    logic  mon_en     = 1'b0;
    logic  prev_valid = 1'b0;
    logic  prev_done  = 1'b0;

    `include "tb_frame_model.svh"

    mac_frame_gen #(.PAYLOAD_LEN(PAYLOAD_LEN), .FILL_BYTE(FILL_BYTE)) DUT (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_dest_addr(i_dest_addr),
        .i_src_addr(i_src_addr), .i_len_type(i_len_type), .i_payload(i_payload),
        .i_mode(i_mode), .o_data(o_data), .o_valid(o_valid), .o_done(o_done)
    );

    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no end of run after %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, sig, exp, act);
        err_cnt++;
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        err_cnt++;
    endtask

    function automatic string field_of(input int idx, input int total);
        if (idx < 8) return "preamble";
        if (idx < 22) return "header";
        if (idx < total - 4) return "payload";
        return "fcs";
    endfunction

    // byte monitor sampling on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (mon_en) begin
            if (o_valid) begin
                run_len = prev_valid ? run_len + 1 : 1;
                if (rx_idx >= exp_q.size()) begin
                    report_error("o_valid high past the end of the frame");
                end else if (o_data !== exp_q[rx_idx]) begin
                    report_mismatch($sformatf("o_data (%s byte %0d)",
                        field_of(rx_idx, exp_q.size()), rx_idx), exp_q[rx_idx], o_data);
                end
                rx_idx++;
            end
            if (o_done && (o_valid || !prev_valid || prev_done)) begin
                report_error("o_done not a single pulse right after the last byte");
            end
            if (prev_valid && !o_valid && !o_done) begin
                report_error("o_valid dropped in the middle of a frame");
            end
            prev_valid = o_valid;
            prev_done  = o_done;
        end
    end

    task automatic check_idle(input string when);
        if (o_valid !== 1'b0) report_mismatch({"o_valid ", when}, 0, o_valid);
        if (o_done !== 1'b0) report_mismatch({"o_done ", when}, 0, o_done);
        if (o_data !== 8'h00) report_mismatch({"o_data ", when}, 0, o_data);
    endtask

    task automatic run_frame(input int n);
        mac_addr_t               dest;
        mac_addr_t               src;
        len_type_t               lt;
        byte_t [PAYLOAD_LEN-1:0] pl;
        payload_mode_t           mode;
        int                      errs0;
        int                      k;
        errs0 = err_cnt;
        dest  = mac_addr_t'({$urandom(), $urandom()});
        src   = mac_addr_t'({$urandom(), $urandom()});
        lt    = len_type_t'($urandom());
        for (int i = 0; i < PAYLOAD_LEN; i++) begin
            pl[i] = byte_t'($urandom());
        end
        mode = (n < 4) ? payload_mode_t'(n) : payload_mode_t'($urandom() % 4); // all modes early
        build_expected(dest, src, lt, pl, mode);
        @(posedge clk);
        rx_idx = 0;
        i_start     <= 1'b1;
        i_dest_addr <= dest;
        i_src_addr  <= src;
        i_len_type  <= lt;
        i_payload   <= pl;
        i_mode      <= mode;
        @(negedge clk);
        if (o_valid !== 1'b0) report_mismatch("o_valid before start sampled", 0, o_valid);
        k = 0;
        do begin
            @(posedge clk);
            k++;
            if (n[0] && k < exp_q.size() - 1) begin
                // junk starts and inputs on odd frames must not disturb them
                i_start     <= 1'($urandom() % 2);
                i_dest_addr <= mac_addr_t'({$urandom(), $urandom()});
                i_src_addr  <= mac_addr_t'({$urandom(), $urandom()});
                i_len_type  <= len_type_t'($urandom());
                i_payload   <= {PAYLOAD_LEN{byte_t'($urandom())}};
                i_mode      <= payload_mode_t'($urandom() % 4);
            end else begin
                i_start <= 1'b0;
            end
            @(negedge clk);
            if (k == 1 && o_valid !== 1'b1) report_mismatch("o_valid first cycle", 1, o_valid);
        end while (o_done !== 1'b1);
        if (rx_idx != exp_q.size()) report_mismatch("frame byte count", exp_q.size(), rx_idx);
        if (run_len != exp_q.size()) report_mismatch("o_valid run length", exp_q.size(), run_len);
        if (err_cnt == errs0) begin
            pass_cnt++;
            $display("frame %0d %s: %0d bytes ok", n, mode.name(), exp_q.size());
        end else begin
            fail_cnt++;
            $display("frame %0d %s: failed", n, mode.name());
        end
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        i_dest_addr = '0;
        i_src_addr  = '0;
        i_len_type  = '0;
        i_payload   = '0;
        i_mode      = MODE_NORMAL;
        seed        = $urandom(38966); // one seed for the whole run
        repeat (4) begin
            @(negedge clk);
            check_idle("in reset");
        end
        @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        check_idle("after reset");
        if (err_cnt == 0) begin
            pass_cnt++;
            $display("reset: ok");
        end else begin
            fail_cnt++;
            $display("reset: failed");
        end
        mon_en = 1'b1;
        for (int n = 0; n < N_FRAMES; n++) begin
            run_frame(n);
        end
        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- mac_frame_gen.sv
module mac_frame_gen #(
    parameter integer                   PAYLOAD_LEN = mac_frame_gen_pkg::DEFAULT_PAYLOAD_LEN,
    parameter mac_frame_gen_pkg::byte_t FILL_BYTE   = mac_frame_gen_pkg::DEFAULT_FILL_BYTE
) (
    input  logic                                       clk,
    input  logic                                       i_rst_n,
    input  logic                                       i_start,
    input  mac_frame_gen_pkg::mac_addr_t               i_dest_addr,
    input  mac_frame_gen_pkg::mac_addr_t               i_src_addr,
    input  mac_frame_gen_pkg::len_type_t               i_len_type,
    input  mac_frame_gen_pkg::byte_t [PAYLOAD_LEN-1:0] i_payload,
    input  mac_frame_gen_pkg::payload_mode_t           i_mode,
    output mac_frame_gen_pkg::byte_t                   o_data,
    output logic                                       o_valid,
    output logic                                       o_done
);

    import mac_frame_gen_pkg::*;

    logic   load;          // capture payload and mode
    index_t payload_index;
    index_t field_len;     // padded or raw length
    byte_t  payload_byte;
    logic   crc_init;
    logic   crc_en;
    byte_t  crc_byte;
    crc_t   fcs;

    frame_sequencer u_seq (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_dest_addr     (i_dest_addr),
        .i_src_addr      (i_src_addr),
        .i_len_type      (i_len_type),
        .i_field_len     (field_len),
        .i_payload_byte  (payload_byte),
        .i_fcs           (fcs),
        .o_load          (load),
        .o_payload_index (payload_index),
        .o_crc_init      (crc_init),
        .o_crc_en        (crc_en),
        .o_crc_byte      (crc_byte),
        .o_data          (o_data),
        .o_valid         (o_valid),
        .o_done          (o_done)
    );

    payload_source #(
        .PAYLOAD_LEN (PAYLOAD_LEN),
        .FILL_BYTE   (FILL_BYTE)
    ) u_payload (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_load         (load),
        .i_payload      (i_payload),
        .i_mode         (i_mode),
        .i_index        (payload_index),
        .o_field_len    (field_len),
        .o_payload_byte (payload_byte)
    );

    // fcs over header and payload field
    crc32_engine u_crc (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_init  (crc_init),
        .i_en    (crc_en),
        .i_byte  (crc_byte),
        .o_fcs   (fcs)
    );

endmodule

//--- frame_sequencer.sv
module frame_sequencer (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,        // ignored unless idle
    input  mac_frame_gen_pkg::mac_addr_t i_dest_addr,
    input  mac_frame_gen_pkg::mac_addr_t i_src_addr,
    input  mac_frame_gen_pkg::len_type_t i_len_type,
    input  mac_frame_gen_pkg::index_t    i_field_len,    // from payload_source
    input  mac_frame_gen_pkg::byte_t     i_payload_byte, // byte at o_payload_index
    input  mac_frame_gen_pkg::crc_t      i_fcs,
    output logic                         o_load,
    output mac_frame_gen_pkg::index_t    o_payload_index,
    output logic                         o_crc_init,
    output logic                         o_crc_en,
    output mac_frame_gen_pkg::byte_t     o_crc_byte,
    output mac_frame_gen_pkg::byte_t     o_data,
    output logic                         o_valid,
    output logic                         o_done
);

    import mac_frame_gen_pkg::*;

    localparam integer HDR_W = HEADER_LEN * 8; // 112 bits

    frame_state_t           state_q;
    frame_state_t           state_d;
    index_t                 cnt_q;     // byte count within current phase
    index_t                 cnt_d;
    logic [HDR_W-1:0]       hdr_q;     // dest|src|len, shifted out msb first
    byte_t                  data_d;    // next o_data
    logic                   valid_d;
    logic                   done_d;
    logic                   start_ok;  // start seen while idle
    byte_t                  fcs_byte;  // fcs byte picked by cnt

    assign start_ok = (state_q == ST_IDLE) && i_start;

    // same pulse loads the payload and resets the crc
    assign o_load     = start_ok;
    assign o_crc_init = start_ok;

    assign o_payload_index = cnt_q; // only looked at in ST_PAYLOAD

    assign fcs_byte = i_fcs[{cnt_q[1:0], 3'b000} +: 8]; // lsb first

    // next state and next output byte
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q + index_t'(1);
        data_d  = 8'h00;
        valid_d = 1'b0;
        done_d  = 1'b0;
        case (state_q)
            ST_IDLE: begin
                cnt_d = '0;
                if (i_start) begin
                    state_d = ST_PREAMBLE;
                    cnt_d   = index_t'(1); // byte 0 goes out now
                    data_d  = PREAMBLE_BYTE;
                    valid_d = 1'b1;
                end
            end
            ST_PREAMBLE: begin
                valid_d = 1'b1;
                if (cnt_q == index_t'(PREAMBLE_LEN - 1)) begin
                    data_d  = SFD_BYTE; // last preamble slot
                    state_d = ST_HEADER;
                    cnt_d   = '0;
                end else begin
                    data_d = PREAMBLE_BYTE;
                end
            end
            ST_HEADER: begin
                valid_d = 1'b1;
                data_d  = hdr_q[HDR_W-1 -: 8];
                if (cnt_q == index_t'(HEADER_LEN - 1)) begin
                    state_d = ST_PAYLOAD;
                    cnt_d   = '0;
                end
            end
            ST_PAYLOAD: begin
                valid_d = 1'b1;
                data_d  = i_payload_byte;
                if (cnt_q == i_field_len - index_t'(1)) begin
                    state_d = ST_FCS;
                    cnt_d   = '0;
                end
            end
            ST_FCS: begin
                if (cnt_q == index_t'(FCS_LEN)) begin
                    // last fcs byte is on o_data this cycle
                    state_d = ST_IDLE;
                    cnt_d   = '0;
                    done_d  = 1'b1;
                end else begin
                    valid_d = 1'b1;
                    data_d  = fcs_byte;
                end
            end
            default: begin
                state_d = ST_IDLE; // unused encodings
                cnt_d   = '0;
            end
        endcase
    end

    // crc sees exactly what o_data gets for header and payload
    assign o_crc_en   = (state_q == ST_HEADER) || (state_q == ST_PAYLOAD);
    assign o_crc_byte = data_d;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            o_data  <= 8'h00;
            o_valid <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            o_data  <= data_d;
            o_valid <= valid_d;
            o_done  <= done_d; // one cycle, back in idle
        end
    end

    // header register, loaded on start and shifted a byte per header cycle
    always_ff @(posedge clk) begin
        if (start_ok) begin
            hdr_q <= {i_dest_addr, i_src_addr, i_len_type};
        end else if (state_q == ST_HEADER) begin
            hdr_q <= {hdr_q[HDR_W-9:0], 8'h00};
        end
    end

endmodule

//--- payload_source.sv
module payload_source #(
    parameter integer                   PAYLOAD_LEN = 46,   // stored bytes, 1..1500
    parameter mac_frame_gen_pkg::byte_t FILL_BYTE   = 8'h00 // fixed mode pattern
) (
    input  logic                                     clk,
    input  logic                                     i_rst_n,
    input  logic                                     i_load,  // capture strobe
    input  mac_frame_gen_pkg::byte_t [PAYLOAD_LEN-1:0] i_payload, // byte 0 in low bits
    input  mac_frame_gen_pkg::payload_mode_t         i_mode,
    input  mac_frame_gen_pkg::index_t                i_index, // position in field
    output mac_frame_gen_pkg::index_t                o_field_len,
    output mac_frame_gen_pkg::byte_t                 o_payload_byte
);

    import mac_frame_gen_pkg::*;

    // field lengths for both padding choices
    localparam index_t RAW_LEN = index_t'(PAYLOAD_LEN);
    localparam index_t PAD_LEN = (PAYLOAD_LEN < MIN_PAYLOAD_LEN) ?
                                 index_t'(MIN_PAYLOAD_LEN) : index_t'(PAYLOAD_LEN);

    byte_t [PAYLOAD_LEN-1:0] payload_q; // snapshot of i_payload
    payload_mode_t           mode_q;
    logic                    use_fill;  // fill byte replaces data
    logic                    use_pad;   // stretch to 46 bytes

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode_q <= MODE_NORMAL;
        end else if (i_load) begin
            mode_q <= i_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            payload_q <= i_payload; // data only, control is above
        end
    end

    // mode decode, nowhere else looks at the mode
    always_comb begin
        case (mode_q)
            MODE_FIXED: begin
                use_fill = 1'b1;
                use_pad  = 1'b1;
            end
            MODE_NO_PAD: begin
                use_fill = 1'b0;
                use_pad  = 1'b0;
            end
            MODE_FIXED_NO_PAD: begin
                use_fill = 1'b1;
                use_pad  = 1'b0;
            end
            default: begin // normal
                use_fill = 1'b0;
                use_pad  = 1'b1;
            end
        endcase
    end

    assign o_field_len = use_pad ? PAD_LEN : RAW_LEN;

    always_comb begin
        if (use_fill) begin
            o_payload_byte = FILL_BYTE;          // pad bytes too
        end else if (i_index < RAW_LEN) begin
            o_payload_byte = payload_q[i_index]; // stored data
        end else begin
            o_payload_byte = 8'h00;              // zero padding
        end
    end

endmodule

//--- crc32_engine.sv
module crc32_engine (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_init, // restart at all ones
    input  logic                    i_en,   // fold i_byte in
    input  mac_frame_gen_pkg::byte_t i_byte,
    output mac_frame_gen_pkg::crc_t  o_fcs   // ready to send
);

    import mac_frame_gen_pkg::*;

    crc_t crc_q;    // running remainder
    crc_t crc_next; // remainder after one more byte

    // byte enters at the low end, lsb first as on the wire
    always_comb begin
        crc_next = crc_q ^ {24'd0, i_byte};
        for (int b = 0; b < 8; b++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ CRC_POLY_REFL; // feedback bit set
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc_q <= CRC_INIT;
        end else if (i_init) begin
            crc_q <= CRC_INIT; // init beats en on the same cycle
        end else if (i_en) begin
            crc_q <= crc_next;
        end
    end

    // final xor, held steady while fcs bytes go out
    assign o_fcs = ~crc_q;

endmodule

//--- mac_frame_gen_pkg.sv
package mac_frame_gen_pkg;

    // widths with a meaning of their own
    typedef logic [7:0]  byte_t;     // one byte on the wire
    typedef logic [47:0] mac_addr_t; // dest / src address
    typedef logic [15:0] len_type_t; // length or ethertype
    typedef logic [31:0] crc_t;      // crc register and fcs
    typedef logic [15:0] index_t;    // byte index inside a frame field

    // bit 0 selects the fill byte, bit 1 drops the padding
    typedef enum logic [1:0] {
        MODE_NORMAL       = 2'd0, // stored payload, zero pad to minimum
        MODE_FIXED        = 2'd1, // fill byte over padded length
        MODE_NO_PAD       = 2'd2, // stored payload only
        MODE_FIXED_NO_PAD = 2'd3  // fill byte over stored length
    } payload_mode_t;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_PREAMBLE = 3'd1, // 7x 0x55 then sfd
        ST_HEADER   = 3'd2, // dest, src, len/type
        ST_PAYLOAD  = 3'd3, // payload field incl. padding
        ST_FCS      = 3'd4  // crc, lsb first
    } frame_state_t;

    // frame constants
    localparam byte_t  PREAMBLE_BYTE   = 8'h55;
    localparam byte_t  SFD_BYTE        = 8'hD5;
    localparam integer PREAMBLE_LEN    = 8;  // sfd counted in
    localparam integer HEADER_LEN      = 14; // 6 + 6 + 2
    localparam integer MIN_PAYLOAD_LEN = 46;
    localparam integer FCS_LEN         = 4;

    // ieee 802.3 crc-32, bit reversed form for lsb-first shifting
    localparam crc_t   CRC_POLY_REFL   = 32'hEDB88320;
    localparam crc_t   CRC_INIT        = 32'hFFFFFFFF;

    // top level defaults
    localparam integer DEFAULT_PAYLOAD_LEN = 20;
    localparam byte_t  DEFAULT_FILL_BYTE   = 8'h55;

endpackage
